// File: source/coupe_macros.svh
`ifndef COUPE_MACROS_SVH
`define COUPE_MACROS_SVH

// ====================
// ASIC port numbers
// ====================

// External RAM page registers
`define PORT_EXT_C      8'h80
`define PORT_EXT_D      8'h81

// Printer port, used as a stereo DAC
`define PORT_LPT_DATA   8'hE8
`define PORT_LPT_STROBE 8'hE9

// Status, paging, MIDI and border
`define PORT_STATUS     8'hF9
`define PORT_LMPR       8'hFA
`define PORT_HMPR       8'hFB
`define PORT_MIDI       8'hFD
`define PORT_BORDER     8'hFE

// ====================
// MIDI timer
// ====================

// System clocks per 1 MHz tick
`define MIDI_TICK_DIV    96
// Length of one transmitted byte in ticks
`define MIDI_FRAME_TICKS 320
// Remaining ticks when the interrupt is raised
`define MIDI_INT_TICK    15

`endif

// File: source/coupe_pkg.sv
package coupe_pkg;

	// ====================
	// Bus and register widths
	// ====================

	// CPU address bus
	typedef logic [15:0] addr_t;

	// Data bus byte and 8-bit ASIC registers
	typedef logic [7:0] data_t;

	// RAM page, top bit selects external RAM
	typedef logic [8:0] page_t;

	// Unsigned audio word for each channel
	typedef logic [15:0] sample_t;

	// ====================
	// State machines
	// ====================

	// MIDI transmitter
	typedef enum logic {
		midi_idle,
		midi_sending
	} midi_state_t;

endpackage

// File: source/asic_port_bus.sv
`timescale 1ns/1ps
`include "coupe_macros.svh"

module asic_port_bus (
	input  logic             clk_sys,
	input  logic             reset,
	input  coupe_pkg::addr_t addr,
	input  logic             iorq_n,
	input  logic             mreq_n,
	input  logic             rd_n,
	input  logic             wr_n,
	input  logic             m1_n,
	input  coupe_pkg::data_t lmpr,
	input  coupe_pkg::data_t hmpr,
	input  logic             int_midi,
	output logic             wr_lmpr,
	output logic             wr_hmpr,
	output logic             wr_ext_c,
	output logic             wr_ext_d,
	output logic             wr_border,
	output logic             wr_lpt_data,
	output logic             wr_lpt_strobe,
	output logic             wr_midi,
	output coupe_pkg::data_t port_dout
);
	import coupe_pkg::*;

	logic  port_we;
	logic  port_rd;
	logic  old_we;
	logic  we_edge;
	data_t port_lo;
	data_t status;
	data_t rd_data;

	// I/O cycle, interrupt acknowledge excluded
	assign port_we = ~iorq_n & mreq_n & ~wr_n & m1_n;
	assign port_rd = ~iorq_n & mreq_n & ~rd_n & m1_n;
	assign port_lo = addr[7:0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_we <= 1'b0;
		end else begin
			old_we <= port_we;
		end
	end

	// Only the first cycle of a write counts
	assign we_edge = port_we & ~old_we;

	assign wr_lmpr       = we_edge & (port_lo == `PORT_LMPR);
	assign wr_hmpr       = we_edge & (port_lo == `PORT_HMPR);
	assign wr_ext_c      = we_edge & (port_lo == `PORT_EXT_C);
	assign wr_ext_d      = we_edge & (port_lo == `PORT_EXT_D);
	assign wr_border     = we_edge & (port_lo == `PORT_BORDER);
	assign wr_lpt_data   = we_edge & (port_lo == `PORT_LPT_DATA);
	assign wr_lpt_strobe = we_edge & (port_lo == `PORT_LPT_STROBE);
	assign wr_midi       = we_edge & (port_lo == `PORT_MIDI);

	// Keys and line/frame interrupts are gone and read as ones
	assign status = {3'b111, 1'b1, ~int_midi, 2'b11, 1'b1};

	always_comb begin
		case (port_lo)
			`PORT_STATUS:     rd_data = status;
			`PORT_LMPR:       rd_data = lmpr;
			`PORT_HMPR:       rd_data = hmpr;
			`PORT_LPT_DATA,
			`PORT_LPT_STROBE: rd_data = 8'h00;
			default:          rd_data = 8'hFF;
		endcase
	end

	// Bus floats high outside a port read
	assign port_dout = port_rd ? rd_data : 8'hFF;

endmodule

// File: source/memory_mapper.sv
`timescale 1ns/1ps

module memory_mapper (
	input  logic             clk_sys,
	input  logic             reset,
	input  coupe_pkg::addr_t addr,
	input  coupe_pkg::data_t cpu_dout,
	input  logic             wr_lmpr,
	input  logic             wr_hmpr,
	input  logic             wr_ext_c,
	input  logic             wr_ext_d,
	input  logic             ext_ram_off,
	output coupe_pkg::data_t lmpr,
	output coupe_pkg::data_t hmpr,
	output coupe_pkg::page_t ram_page,
	output logic             rom_sel,
	output logic             ram_wp,
	output logic             ext_ena
);
	import coupe_pkg::*;

	data_t      ext_c;
	data_t      ext_d;
	logic       ext_dis;
	logic [1:0] quarter;
	logic [4:0] page_ab;
	logic [4:0] page_cd;
	logic       ext_ram;
	logic       rom0_sel;
	logic       rom1_sel;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lmpr    <= '0;
			hmpr    <= '0;
			ext_c   <= '0;
			ext_d   <= '0;
			// Board switch, only looked at during reset
			ext_dis <= ext_ram_off;
		end else begin
			if (wr_lmpr)  lmpr  <= cpu_dout;
			if (wr_hmpr)  hmpr  <= cpu_dout;
			if (wr_ext_c) ext_c <= cpu_dout;
			if (wr_ext_d) ext_d <= cpu_dout;
		end
	end

	assign quarter = addr[15:14];
	assign page_ab = lmpr[4:0];
	assign page_cd = hmpr[4:0];

	// ROM0 low, ROM1 high
	assign rom0_sel = ~lmpr[5] & (quarter == 2'd0);
	assign rom1_sel = lmpr[6] & (quarter == 2'd3);
	assign rom_sel  = rom0_sel | rom1_sel;
	assign ram_wp   = lmpr[7] & (quarter == 2'd0);

	// Upper 32K from external RAM
	assign ext_ram = hmpr[7] & addr[15];
	assign ext_ena = ~(ext_ram & ext_dis);

	always_comb begin
		if (ext_ram) begin
			ram_page = addr[14] ? {1'b1, ext_d} : {1'b1, ext_c};
		end else begin
			case (quarter)
				2'd0:    ram_page = page_t'(page_ab);
				2'd1:    ram_page = page_t'(5'(page_ab + 5'd1));
				2'd2:    ram_page = page_t'(page_cd);
				default: ram_page = page_t'(5'(page_cd + 5'd1));
			endcase
		end
	end

endmodule

// File: source/sound_dac.sv
`timescale 1ns/1ps

module sound_dac (
	input  logic               clk_sys,
	input  logic               reset,
	input  coupe_pkg::data_t   cpu_dout,
	input  logic               wr_border,
	input  logic               wr_lpt_data,
	input  logic               wr_lpt_strobe,
	output coupe_pkg::sample_t audio_l,
	output coupe_pkg::sample_t audio_r
);
	import coupe_pkg::*;

	logic  ear;
	logic  old_stb;
	data_t latch;
	data_t vox_l;
	data_t vox_r;

	// Sample scaled by 1028 plus beeper at half scale, then / 8
	function automatic sample_t mix(input data_t smp, input logic ear_bit);
		logic [18:0] sum;
		sum = {1'b0, smp, smp, 2'b00} + {3'b000, ear_bit, 15'd0};
		return sum[18:3];
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ear     <= 1'b0;
			old_stb <= 1'b0;
			latch   <= '0;
			vox_l   <= '0;
			vox_r   <= '0;
		end else begin
			if (wr_border)   ear   <= cpu_dout[4];
			if (wr_lpt_data) latch <= cpu_dout;
			// Strobe edge picks the channel
			if (wr_lpt_strobe) begin
				if (~old_stb & cpu_dout[0]) vox_l <= latch;
				if (old_stb & ~cpu_dout[0]) vox_r <= latch;
				old_stb <= cpu_dout[0];
			end
		end
	end

	assign audio_l = mix(vox_l, ear);
	assign audio_r = mix(vox_r, ear);

endmodule

// File: source/midi_tx_timer.sv
`timescale 1ns/1ps
`include "coupe_macros.svh"

module midi_tx_timer (
	input  logic clk_sys,
	input  logic reset,
	input  logic wr_midi,
	output logic midi_tx,
	output logic int_midi
);
	import coupe_pkg::*;

	localparam int TICK_W  = $clog2(`MIDI_TICK_DIV);
	localparam int FRAME_W = $clog2(`MIDI_FRAME_TICKS);

	logic [TICK_W-1:0]  tick_cnt;
	logic [FRAME_W-1:0] frame_cnt;
	logic               tick;
	logic               pending;
	midi_state_t        state;

	// 1 MHz tick from the system clock
	assign tick = (tick_cnt == TICK_W'(`MIDI_TICK_DIV - 1));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tick_cnt  <= '0;
			frame_cnt <= '0;
			pending   <= 1'b0;
			int_midi  <= 1'b0;
			state     <= midi_idle;
		end else begin
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			if (tick) begin
				case (state)
					midi_idle: begin
						if (pending) begin
							state     <= midi_sending;
							frame_cnt <= FRAME_W'(`MIDI_FRAME_TICKS - 1);
							pending   <= 1'b0;
						end
					end
					default: begin
						if (frame_cnt != '0) begin
							frame_cnt <= frame_cnt - 1'b1;
							if (frame_cnt == FRAME_W'(`MIDI_INT_TICK)) int_midi <= 1'b1;
						end else begin
							// Frame done
							state    <= midi_idle;
							int_midi <= 1'b0;
						end
					end
				endcase
			end
			// A new write wins over the clear at start
			if (wr_midi) pending <= 1'b1;
		end
	end

	assign midi_tx = (state == midi_sending);

endmodule

// File: source/coupe_asic_top.sv
`timescale 1ns/1ps

module coupe_asic_top (
	input  logic               clk_sys,
	input  logic               reset,
	input  coupe_pkg::addr_t   addr,
	input  coupe_pkg::data_t   cpu_dout,
	input  logic               iorq_n,
	input  logic               mreq_n,
	input  logic               rd_n,
	input  logic               wr_n,
	input  logic               m1_n,
	input  logic               ext_ram_off,
	output coupe_pkg::data_t   port_dout,
	output coupe_pkg::page_t   ram_page,
	output logic               rom_sel,
	output logic               ram_wp,
	output logic               ext_ena,
	output coupe_pkg::sample_t audio_l,
	output coupe_pkg::sample_t audio_r,
	output logic               midi_tx,
	output logic               int_midi
);
	import coupe_pkg::*;

	data_t lmpr;
	data_t hmpr;
	logic  wr_lmpr;
	logic  wr_hmpr;
	logic  wr_ext_c;
	logic  wr_ext_d;
	logic  wr_border;
	logic  wr_lpt_data;
	logic  wr_lpt_strobe;
	logic  wr_midi;

	// ====================
	// Port decode and readback
	// ====================
	asic_port_bus asic_port_bus_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.addr          (addr),
		.iorq_n        (iorq_n),
		.mreq_n        (mreq_n),
		.rd_n          (rd_n),
		.wr_n          (wr_n),
		.m1_n          (m1_n),
		.lmpr          (lmpr),
		.hmpr          (hmpr),
		.int_midi      (int_midi),
		.wr_lmpr       (wr_lmpr),
		.wr_hmpr       (wr_hmpr),
		.wr_ext_c      (wr_ext_c),
		.wr_ext_d      (wr_ext_d),
		.wr_border     (wr_border),
		.wr_lpt_data   (wr_lpt_data),
		.wr_lpt_strobe (wr_lpt_strobe),
		.wr_midi       (wr_midi),
		.port_dout     (port_dout)
	);

	// ====================
	// Paging
	// ====================
	memory_mapper memory_mapper_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.addr        (addr),
		.cpu_dout    (cpu_dout),
		.wr_lmpr     (wr_lmpr),
		.wr_hmpr     (wr_hmpr),
		.wr_ext_c    (wr_ext_c),
		.wr_ext_d    (wr_ext_d),
		.ext_ram_off (ext_ram_off),
		.lmpr        (lmpr),
		.hmpr        (hmpr),
		.ram_page    (ram_page),
		.rom_sel     (rom_sel),
		.ram_wp      (ram_wp),
		.ext_ena     (ext_ena)
	);

	// ====================
	// Audio and MIDI
	// ====================
	sound_dac sound_dac_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cpu_dout      (cpu_dout),
		.wr_border     (wr_border),
		.wr_lpt_data   (wr_lpt_data),
		.wr_lpt_strobe (wr_lpt_strobe),
		.audio_l       (audio_l),
		.audio_r       (audio_r)
	);

	midi_tx_timer midi_tx_timer_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.wr_midi  (wr_midi),
		.midi_tx  (midi_tx),
		.int_midi (int_midi)
	);

endmodule

// File: bench/coupe_checker.sv
`timescale 1ns/1ps

module coupe_checker (
	input coupe_pkg::data_t   port_dout,
	input coupe_pkg::page_t   ram_page,
	input logic               rom_sel,
	input logic               ram_wp,
	input logic               ext_ena,
	input coupe_pkg::sample_t audio_l,
	input coupe_pkg::sample_t audio_r,
	input logic               midi_tx,
	input logic               int_midi
);
	import coupe_pkg::*;

	int check_count = 0;
	int error_count = 0;

	task automatic compare_value(input string name, input int expected, input int actual);
		check_count++;
		if (expected != actual) begin
			error_count++;
			$display("mismatch at %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	// Clock counts with a tolerance
	task automatic compare_span(input string name, input int expected, input int tol,
			input int actual);
		check_count++;
		if (actual < expected - tol || actual > expected + tol) begin
			error_count++;
			$display("mismatch at %0t ns: %s expected %0d +/- %0d clocks, got %0d",
				$time, name, expected, tol, actual);
		end
	endtask

	task automatic compare_port(input data_t expected);
		compare_value("port_dout", expected, port_dout);
	endtask

	// Flags are rom_sel, ram_wp, ext_ena
	task automatic compare_mapping(input page_t page, input logic [2:0] flags);
		compare_value("ram_page", page, ram_page);
		compare_value("rom_sel", flags[2], rom_sel);
		compare_value("ram_wp", flags[1], ram_wp);
		compare_value("ext_ena", flags[0], ext_ena);
	endtask

	task automatic compare_audio(input sample_t left, input sample_t right);
		compare_value("audio_l", left, audio_l);
		compare_value("audio_r", right, audio_r);
	endtask

	task automatic compare_midi(input logic tx, input logic irq);
		compare_value("midi_tx", tx, midi_tx);
		compare_value("int_midi", irq, int_midi);
	endtask

	task automatic report_failure(input string what);
		error_count++;
		$display("Error at %0t ns: %s", $time, what);
	endtask

	task automatic print_counts();
		$display("%0d checks, %0d errors", check_count, error_count);
	endtask

endmodule

// File: bench/coupe_asserts.sv
`timescale 1ns/1ps

module coupe_asserts (
	input logic clk_sys,
	input logic reset,
	input logic iorq_n,
	input logic mreq_n,
	input logic wr_n,
	input logic m1_n,
	input logic wr_lmpr,
	input logic wr_hmpr,
	input logic wr_ext_c,
	input logic wr_ext_d,
	input logic wr_border,
	input logic wr_lpt_data,
	input logic wr_lpt_strobe,
	input logic wr_midi,
	input logic midi_tx,
	input logic int_midi
);
	logic [7:0] pulses;
	logic       port_we;
	logic       pulse_seen;

	assign pulses  = {wr_lmpr, wr_hmpr, wr_ext_c, wr_ext_d,
		wr_border, wr_lpt_data, wr_lpt_strobe, wr_midi};
	assign port_we = ~iorq_n & mreq_n & ~wr_n & m1_n;

	// Set by the first pulse of a write, cleared when the write ends
	always_ff @(posedge clk_sys) begin
		if (reset || !port_we) begin
			pulse_seen <= 1'b0;
		end else if (|pulses) begin
			pulse_seen <= 1'b1;
		end
	end

	// At most one decoded pulse over the whole write level
	single_write_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0(pulses) && !(pulse_seen && (|pulses)))
		else $error("more than one write pulse for one port write");

	midi_idle_after_reset: assert property (@(posedge clk_sys) reset |=> !midi_tx && !int_midi)
		else $error("MIDI outputs active after reset");

	irq_within_frame: assert property (@(posedge clk_sys) disable iff (reset) int_midi |-> midi_tx)
		else $error("int_midi high while midi_tx is low");

endmodule

bind coupe_asic_top coupe_asserts coupe_asserts_i (.*);

// File: bench/tb_coupe_asic.sv
`timescale 1ns/1ps
`include "coupe_macros.svh"

module tb_coupe_asic;
	import coupe_pkg::*;

	localparam int OP_WRITE   = 0;
	localparam int OP_HELD    = 1;
	localparam int OP_READ    = 2;
	localparam int OP_PROBE   = 3;
	localparam int OP_AUDIO   = 4;
	localparam int OP_RESET   = 5;
	localparam int OP_MIDI    = 6;
	localparam int FRAME_CLKS = `MIDI_FRAME_TICKS * `MIDI_TICK_DIV;
	localparam int IRQ_CLKS   = `MIDI_INT_TICK * `MIDI_TICK_DIV;

	// One row of the stimulus table
	typedef struct {
		int         op;
		addr_t      addr;
		data_t      data;
		int         exp_a;
		int         exp_b;
		logic [2:0] flags;
	} entry_t;

	logic    clk_sys;
	logic    reset;
	addr_t   addr;
	data_t   cpu_dout;
	logic    iorq_n;
	logic    mreq_n;
	logic    rd_n;
	logic    wr_n;
	logic    m1_n;
	logic    ext_ram_off;
	data_t   port_dout;
	page_t   ram_page;
	logic    rom_sel;
	logic    ram_wp;
	logic    ext_ena;
	sample_t audio_l;
	sample_t audio_r;
	logic    midi_tx;
	logic    int_midi;
	entry_t  steps[$];
	bit      timed_out;

	coupe_asic_top coupe_asic_top_i (.*);

	coupe_checker coupe_checker_i (.*);

	always #10 clk_sys = ~clk_sys;

	// Audio rule, result rounded down
	function automatic int audio_level(input data_t smp, input logic ear_on);
		return (int'(smp) * 1028 + int'(ear_on) * 32768) / 8;
	endfunction

	task automatic add_step(input int op, input addr_t a, input data_t d, input int ea,
			input int eb, input logic [2:0] f);
		entry_t e;
		e.op    = op;
		e.addr  = a;
		e.data  = d;
		e.exp_a = ea;
		e.exp_b = eb;
		e.flags = f;
		steps.push_back(e);
	endtask

	task automatic release_bus();
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
	endtask

	task automatic drive_bus(input addr_t a, input data_t d, input logic is_io, input logic is_wr);
		@(posedge clk_sys);
		#2;
		addr     = a;
		cpu_dout = d;
		iorq_n   = ~is_io;
		mreq_n   = is_io;
		rd_n     = is_wr;
		wr_n     = ~is_wr;
	endtask

	task automatic apply_reset(input logic ext_off);
		@(posedge clk_sys);
		#2;
		reset       = 1'b1;
		ext_ram_off = ext_off;
		release_bus();
		repeat (10) @(posedge clk_sys);
		#2;
		reset       = 1'b0;
		// Flip the switch so a late sample would show
		ext_ram_off = ~ext_off;
	endtask

	// ====================
	// MIDI frame
	// ====================
	task automatic run_midi_frame();
		int   clk_n;
		int   rise_at;
		int   irq_at;
		logic prev_irq;
		// Transmitter must be idle before the write
		coupe_checker_i.compare_midi(1'b0, 1'b0);
		drive_bus({8'h00, `PORT_MIDI}, 8'h90, 1'b1, 1'b1);
		clk_n    = 0;
		rise_at  = 0;
		irq_at   = 0;
		prev_irq = 1'b0;
		while (!timed_out) begin
			@(posedge clk_sys);
			#2;
			clk_n++;
			if (clk_n == 3 || (irq_at != 0 && clk_n == irq_at + 3)) release_bus();
			if (rise_at == 0 && midi_tx) rise_at = clk_n;
			if (rise_at == 0 && clk_n >= 100) begin
				coupe_checker_i.report_failure("midi_tx did not rise within 100 clocks of the write");
				timed_out = 1'b1;
			end
			if (irq_at != 0 && clk_n == irq_at + 1) coupe_checker_i.compare_port(8'hF7);
			// Read the status port while the interrupt is up
			if (irq_at == 0 && int_midi) begin
				irq_at = clk_n;
				addr   = {8'h00, `PORT_STATUS};
				iorq_n = 1'b0;
				rd_n   = 1'b0;
			end
			if (rise_at != 0 && !midi_tx) begin
				coupe_checker_i.compare_span("midi_tx width", FRAME_CLKS, `MIDI_TICK_DIV,
					clk_n - rise_at);
				coupe_checker_i.compare_span("int_midi width", IRQ_CLKS, `MIDI_TICK_DIV,
					clk_n - irq_at);
				coupe_checker_i.compare_value("int_midi", 0, int_midi);
				if (!prev_irq) coupe_checker_i.report_failure("int_midi was low as midi_tx fell");
				break;
			end
			if (clk_n > FRAME_CLKS + 300) begin
				coupe_checker_i.report_failure("midi_tx stayed high past the frame time");
				timed_out = 1'b1;
			end
			prev_irq = int_midi;
		end
	endtask

	task automatic run_step(input entry_t e);
		case (e.op)
			OP_RESET: apply_reset(e.data[0]);
			OP_MIDI:  run_midi_frame();
			OP_AUDIO: begin
				@(negedge clk_sys);
				coupe_checker_i.compare_audio(sample_t'(e.exp_a), sample_t'(e.exp_b));
			end
			default: begin
				drive_bus(e.addr, e.data, e.op != OP_PROBE, e.op == OP_WRITE || e.op == OP_HELD);
				@(posedge clk_sys);
				// Data changes after the first cycle and must not load
				if (e.op == OP_HELD) begin
					#2;
					cpu_dout = ~e.data;
				end
				@(posedge clk_sys);
				@(negedge clk_sys);
				if (e.op == OP_READ) coupe_checker_i.compare_port(data_t'(e.exp_a));
				if (e.op == OP_PROBE) coupe_checker_i.compare_mapping(page_t'(e.exp_a), e.flags);
				@(posedge clk_sys);
				#2;
				release_bus();
			end
		endcase
	endtask

	// ====================
	// Stimulus table
	// ====================
	task automatic build_steps();
		data_t s0;
		data_t s1;
		data_t s2;
		data_t s3;
		s0 = data_t'($urandom);
		s1 = data_t'($urandom);
		s2 = data_t'($urandom);
		s3 = data_t'($urandom);
		// Reset values and readback
		add_step(OP_RESET, 16'h0000, 8'h00, 0, 0, 3'b000);
		add_step(OP_READ, {8'h12, `PORT_LMPR}, 8'h00, 8'h00, 0, 3'b000);
		add_step(OP_READ, {8'h34, `PORT_HMPR}, 8'h00, 8'h00, 0, 3'b000);
		add_step(OP_READ, {8'h00, `PORT_STATUS}, 8'h00, 8'hFF, 0, 3'b000);
		add_step(OP_WRITE, {8'h56, `PORT_LMPR}, 8'h35, 0, 0, 3'b000);
		add_step(OP_READ, {8'h00, `PORT_LMPR}, 8'h00, 8'h35, 0, 3'b000);
		add_step(OP_HELD, {8'h00, `PORT_HMPR}, 8'h5A, 0, 0, 3'b000);
		add_step(OP_READ, {8'h00, `PORT_HMPR}, 8'h00, 8'h5A, 0, 3'b000);
		// Paging with ROM0 and write protect
		add_step(OP_WRITE, {8'h00, `PORT_LMPR}, 8'h83, 0, 0, 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_HMPR}, 8'h0A, 0, 0, 3'b000);
		add_step(OP_PROBE, 16'h1234, 8'h00, 9'h003, 0, 3'b111);
		add_step(OP_PROBE, 16'h5678, 8'h00, 9'h004, 0, 3'b001);
		add_step(OP_PROBE, 16'h9ABC, 8'h00, 9'h00A, 0, 3'b001);
		add_step(OP_PROBE, 16'hDEF0, 8'h00, 9'h00B, 0, 3'b001);
		// ROM1 on, pages wrap at 32
		add_step(OP_WRITE, {8'h00, `PORT_LMPR}, 8'h7F, 0, 0, 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_HMPR}, 8'h1F, 0, 0, 3'b000);
		add_step(OP_PROBE, 16'h0000, 8'h00, 9'h01F, 0, 3'b001);
		add_step(OP_PROBE, 16'h4000, 8'h00, 9'h000, 0, 3'b001);
		add_step(OP_PROBE, 16'h8000, 8'h00, 9'h01F, 0, 3'b001);
		add_step(OP_PROBE, 16'hC000, 8'h00, 9'h000, 0, 3'b101);
		// External RAM, switch sampled low
		add_step(OP_WRITE, {8'h00, `PORT_LMPR}, 8'h20, 0, 0, 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_EXT_C}, 8'h45, 0, 0, 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_EXT_D}, 8'hB2, 0, 0, 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_HMPR}, 8'h83, 0, 0, 3'b000);
		add_step(OP_PROBE, 16'h8100, 8'h00, 9'h145, 0, 3'b001);
		add_step(OP_PROBE, 16'hC123, 8'h00, 9'h1B2, 0, 3'b001);
		add_step(OP_PROBE, 16'h4000, 8'h00, 9'h001, 0, 3'b001);
		// Switch sampled high
		add_step(OP_RESET, 16'h0000, 8'h01, 0, 0, 3'b000);
		add_step(OP_READ, {8'h00, `PORT_LMPR}, 8'h00, 8'h00, 0, 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_EXT_C}, 8'h11, 0, 0, 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_EXT_D}, 8'hEE, 0, 0, 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_HMPR}, 8'h80, 0, 0, 3'b000);
		add_step(OP_PROBE, 16'h8000, 8'h00, 9'h111, 0, 3'b000);
		add_step(OP_PROBE, 16'hFFFF, 8'h00, 9'h1EE, 0, 3'b000);
		add_step(OP_PROBE, 16'h2000, 8'h00, 9'h000, 0, 3'b101);
		// Printer DAC, beeper off then on
		add_step(OP_WRITE, {8'h00, `PORT_LPT_DATA}, s0, 0, 0, 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_LPT_STROBE}, 8'h01, 0, 0, 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_LPT_DATA}, s1, 0, 0, 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_LPT_STROBE}, 8'h00, 0, 0, 3'b000);
		add_step(OP_AUDIO, 16'h0000, 8'h00, audio_level(s0, 0), audio_level(s1, 0), 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_BORDER}, 8'h10, 0, 0, 3'b000);
		add_step(OP_AUDIO, 16'h0000, 8'h00, audio_level(s0, 1), audio_level(s1, 1), 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_LPT_DATA}, s2, 0, 0, 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_LPT_STROBE}, 8'h01, 0, 0, 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_LPT_DATA}, s3, 0, 0, 3'b000);
		add_step(OP_WRITE, {8'h00, `PORT_LPT_STROBE}, 8'h00, 0, 0, 3'b000);
		add_step(OP_AUDIO, 16'h0000, 8'h00, audio_level(s2, 1), audio_level(s3, 1), 3'b000);
		add_step(OP_READ, {8'h00, `PORT_LPT_DATA}, 8'h00, 8'h00, 0, 3'b000);
		// MIDI transmit
		add_step(OP_MIDI, 16'h0000, 8'h00, 0, 0, 3'b000);
		add_step(OP_READ, {8'h00, `PORT_STATUS}, 8'h00, 8'hFF, 0, 3'b000);
	endtask

	initial begin
		void'($urandom(22655));
		clk_sys     = 1'b0;
		reset       = 1'b1;
		addr        = '0;
		cpu_dout    = '0;
		m1_n        = 1'b1;
		ext_ram_off = 1'b0;
		timed_out   = 1'b0;
		release_bus();
		build_steps();
		for (int i = 0; i < steps.size() && !timed_out; i++) begin
			run_step(steps[i]);
		end
		coupe_checker_i.print_counts();
		if (coupe_checker_i.error_count == 0 && !timed_out) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+source
source/coupe_pkg.sv
source/asic_port_bus.sv
source/memory_mapper.sv
source/sound_dac.sv
source/midi_tx_timer.sv
source/coupe_asic_top.sv
bench/coupe_checker.sv
bench/coupe_asserts.sv
bench/tb_coupe_asic.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_coupe_asic \
	-f sources.f -o sim_coupe > build.log 2>&1 \
	&& ./obj_dir/sim_coupe > sim.log 2>&1

grep -qx "Finished with no errors" sim.log && echo "PASS" \
	|| { echo "FAIL, see build.log and sim.log"; exit 1; }
